// File: mulCluster.f
src/mulPkg.sv
src/mulDatapath.sv
src/mulControl.sv
src/mulEngine.sv
src/mulDispatch.sv
src/resultArbiter.sv
src/mulCluster.sv
verif/mulClusterTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP = mulClusterTb
FILELIST = mulCluster.f
BUILD_DIR = obj_dir
PASS_MSG = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/mulClusterTb.sv
`timescale 1ns/1ps
`default_nettype none

module mulClusterTb;

	localparam int NUM_ENGINES = 2;
	localparam int DW = mulPkg::DATA_WIDTH;
	localparam int TW = mulPkg::TAG_WIDTH;
	localparam int PW = 2 * DW;
	localparam int NUM_TAGS = 1 << TW;
	localparam int NUM_RANDOM = 48;
	localparam int NUM_DIRECTED = 12;
	localparam int NUM_REQS = NUM_RANDOM + NUM_DIRECTED;
	// Own finish time plus one grant behind the other engine
	localparam int LAT_MAX = 2 * (DW + 1) + 2;
	localparam int WATCHDOG_CYCLES = (NUM_REQS + 4) * (DW + 8);

	logic clk = 1'b0;
	logic arstN;
	logic reqVld;
	mulPkg::mulReq_t req;
	logic full;
	logic resVld;
	mulPkg::mulRes_t res;

	// Scoreboard, indexed by tag
	logic [PW-1:0] expProd [NUM_TAGS];
	bit pending [NUM_TAGS];
	int issueCycle [NUM_TAGS];
	int pendingCount = 0;
	int cycleCount = 0;

	logic [31:0] rngState = 32'd54410;
	logic [TW-1:0] nextTag = '0;

	mulCluster #(
		.NUM_ENGINES (NUM_ENGINES)
	) DUT (
		.clk    (clk),
		.arstN  (arstN),
		.reqVld (reqVld),
		.req    (req),
		.full   (full),
		.resVld (resVld),
		.res    (res)
	);

	always #4 clk = ~clk;

	task automatic stopWithFailure(input string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic reportMismatch(input string name, input logic [PW-1:0] got,
		input logic [PW-1:0] exp);
		stopWithFailure($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic nextRandom(output logic [31:0] r);
		rngState = xorshift32(rngState);
		r = rngState;
	endtask

	// Next tag that has no result outstanding
	task automatic pickTag(output logic [TW-1:0] tag);
		tag = nextTag;
		while (pending[tag]) begin
			tag = tag + 1'b1;
		end
		nextTag = tag + 1'b1;
	endtask

	// Called 1 ns after a rising edge, returns 1 ns after the next one
	task automatic driveReq(input logic [DW-1:0] a, input logic [DW-1:0] b,
		input logic [TW-1:0] tag);
		reqVld = 1'b1;
		req = '{a: a, b: b, tag: tag};
		@(posedge clk);
		#1;
		reqVld = 1'b0;
	endtask

	task automatic sendReq(input logic [DW-1:0] a, input logic [DW-1:0] b);
		logic [TW-1:0] tag;
		while (full) begin
			@(posedge clk);
			#1;
		end
		pickTag(tag);
		driveReq(a, b, tag);
	endtask

	task automatic waitDrained();
		int waited;
		waited = 0;
		while (pendingCount != 0 && waited < LAT_MAX + 4) begin
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	// Accepted requests enter, returned results leave
	always @(posedge clk) begin
		int delta;
		delta = 0;
		cycleCount <= cycleCount + 1;
		if (arstN) begin
			if (reqVld && !full) begin
				expProd[req.tag] <= PW'(req.a) * PW'(req.b);
				pending[req.tag] <= 1'b1;
				issueCycle[req.tag] <= cycleCount;
				delta = delta + 1;
			end
			if (resVld) begin
				pending[res.tag] <= 1'b0;
				delta = delta - 1;
			end
		end
		pendingCount <= pendingCount + delta;
	end

	assert property (@(posedge clk) disable iff (!arstN) resVld |-> pending[res.tag])
		else stopWithFailure($sformatf("Result arrived for tag 0x%0h, which is not outstanding",
			$sampled(res.tag)));

	assert property (@(posedge clk) disable iff (!arstN)
		resVld |-> res.prod == expProd[res.tag])
		else reportMismatch("res.prod", $sampled(res.prod), $sampled(expProd[res.tag]));

	assert property (@(posedge clk) disable iff (!arstN)
		resVld |-> cycleCount - issueCycle[res.tag] <= LAT_MAX)
		else stopWithFailure($sformatf("Result for tag 0x%0h came later than %0d cycles",
			$sampled(res.tag), LAT_MAX));

	// Outputs stay quiet while reset is held
	assert property (@(posedge clk) !arstN |-> !resVld && !full)
		else stopWithFailure("resVld or full went high while reset was asserted");

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stopWithFailure($sformatf("Timeout after %0d cycles with %0d results outstanding",
			WATCHDOG_CYCLES, pendingCount));
	end

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [TW-1:0] longTag;
		logic [TW-1:0] shortTag;
		logic [TW-1:0] dropTag;
		arstN = 1'b0;
		reqVld = 1'b0;
		req = '0;
		repeat (4) @(posedge clk);
		#1;
		arstN = 1'b1;
		assert (!resVld) else reportMismatch("resVld", PW'(resVld), '0);
		assert (!full) else reportMismatch("full", PW'(full), '0);

		// Zero, one and max corners
		nextRandom(r);
		sendReq(32'd0, r);
		nextRandom(r);
		sendReq(r, 32'd0);
		nextRandom(r);
		sendReq(32'd1, r);
		nextRandom(r);
		sendReq(r, 32'd1);
		sendReq(32'hFFFF_FFFF, 32'hFFFF_FFFF);
		for (int k = 0; k < 4; k++) begin
			sendReq(32'd1 << (k * 9), 32'h8000_0000 >> (k * 7));
		end
		waitDrained();

		// Long multiplier on engine 0, short one on engine 1
		nextRandom(a);
		pickTag(longTag);
		driveReq(a, 32'hFFFF_FFFF, longTag);
		nextRandom(a);
		pickTag(shortTag);
		driveReq(a, 32'd3, shortTag);
		assert (full) else reportMismatch("full", PW'(full), PW'(1));
		// Both busy, so this one must vanish
		pickTag(dropTag);
		driveReq(32'hDEAD_BEEF, 32'd7, dropTag);
		while (pending[shortTag]) begin
			@(posedge clk);
			#1;
		end
		assert (pending[longTag])
			else stopWithFailure("Short multiply did not return ahead of the long one");
		waitDrained();

		// Random traffic, multiplier length varies with the shift
		for (int n = 0; n < NUM_RANDOM; n++) begin
			nextRandom(a);
			nextRandom(b);
			nextRandom(r);
			sendReq(a, b >> r[4:0]);
			repeat (r[9:8] % 3) begin
				@(posedge clk);
				#1;
			end
		end
		waitDrained();

		if (pendingCount == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			stopWithFailure($sformatf("%0d results never returned", pendingCount));
		end
	end

endmodule

`default_nettype wire

// File: src/mulCluster.sv
`timescale 1ns/1ps
`default_nettype none

module mulCluster #(
	parameter int NUM_ENGINES = 2
) (
	input  wire                   clk,
	input  wire                   arstN,
	input  wire                   reqVld,
	input  wire  mulPkg::mulReq_t req,
	output logic                  full,
	output logic                  resVld,
	output mulPkg::mulRes_t       res
);

	logic [NUM_ENGINES-1:0] idle;
	logic [NUM_ENGINES-1:0] start;
	logic [NUM_ENGINES-1:0] done;
	logic [NUM_ENGINES-1:0] grant;
	mulPkg::mulRes_t engRes [NUM_ENGINES];

	mulDispatch #(
		.NUM_ENGINES (NUM_ENGINES)
	) dispatch (
		.reqVld (reqVld),
		.idle   (idle),
		.start  (start),
		.full   (full)
	);

	// Every engine sees the request, only the started one loads it
	for (genvar g = 0; g < NUM_ENGINES; g++) begin : genEngine
		mulEngine engine (
			.clk   (clk),
			.arstN (arstN),
			.start (start[g]),
			.req   (req),
			.grant (grant[g]),
			.idle  (idle[g]),
			.done  (done[g]),
			.res   (engRes[g])
		);
	end

	resultArbiter #(
		.NUM_ENGINES (NUM_ENGINES)
	) arbiter (
		.clk    (clk),
		.arstN  (arstN),
		.done   (done),
		.engRes (engRes),
		.grant  (grant),
		.resVld (resVld),
		.res    (res)
	);

endmodule

`default_nettype wire

// File: src/resultArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module resultArbiter #(
	parameter int NUM_ENGINES = 2
) (
	input  wire                    clk,
	input  wire                    arstN,
	input  wire  [NUM_ENGINES-1:0] done,
	input  wire  mulPkg::mulRes_t  engRes [NUM_ENGINES],
	output logic [NUM_ENGINES-1:0] grant,
	output logic                   resVld,
	output mulPkg::mulRes_t        res
);

	localparam int PTR_WIDTH = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;

	logic [PTR_WIDTH-1:0] ptr;
	logic [PTR_WIDTH-1:0] grantIdx;
	logic [PTR_WIDTH-1:0] ptrNext;
	logic found;

	// Scan from the pointer, first done engine gets the bus
	always_comb begin
		int idx;
		grant = '0;
		grantIdx = '0;
		found = 1'b0;
		for (int k = 0; k < NUM_ENGINES; k++) begin
			idx = (int'(ptr) + k) % NUM_ENGINES;
			if (!found && done[idx]) begin
				grant[idx] = 1'b1;
				grantIdx = PTR_WIDTH'(idx);
				found = 1'b1;
			end
		end
	end

	// One past the winner
	assign ptrNext = (int'(grantIdx) == NUM_ENGINES - 1) ? '0 : grantIdx + PTR_WIDTH'(1);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ptr <= '0;
			resVld <= 1'b0;
		end else begin
			resVld <= found;
			if (found) begin
				ptr <= ptrNext;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (found) begin
			res <= engRes[grantIdx];
		end
	end

endmodule

`default_nettype wire

// File: src/mulDispatch.sv
`timescale 1ns/1ps
`default_nettype none

module mulDispatch #(
	parameter int NUM_ENGINES = 2
) (
	input  wire                    reqVld,
	input  wire  [NUM_ENGINES-1:0] idle,
	output logic [NUM_ENGINES-1:0] start,
	output logic                   full
);

	logic picked;

	// All engines busy
	assign full = &(~idle);

	// Lowest idle engine wins the request
	always_comb begin
		start = '0;
		picked = 1'b0;
		for (int i = 0; i < NUM_ENGINES; i++) begin
			if (reqVld && idle[i] && !picked) begin
				start[i] = 1'b1;
				picked = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/mulEngine.sv
`timescale 1ns/1ps
`default_nettype none

module mulEngine (
	input  wire               clk,
	input  wire               arstN,
	input  wire               start,
	input  wire  mulPkg::mulReq_t req,
	input  wire               grant,
	output logic              idle,
	output logic              done,
	output mulPkg::mulRes_t   res
);

	mulPkg::mulCtrl_t ctrl;
	logic bLsb;
	logic bZero;
	logic [mulPkg::PROD_WIDTH-1:0] prod;
	logic [mulPkg::TAG_WIDTH-1:0] tagReg;

	mulControl control (
		.clk   (clk),
		.arstN (arstN),
		.start (start),
		.bLsb  (bLsb),
		.bZero (bZero),
		.grant (grant),
		.ctrl  (ctrl),
		.idle  (idle),
		.done  (done)
	);

	mulDatapath datapath (
		.clk   (clk),
		.arstN (arstN),
		.ctrl  (ctrl),
		.opA   (req.a),
		.opB   (req.b),
		.bZero (bZero),
		.bLsb  (bLsb),
		.prod  (prod)
	);

	// Tag rides along with the product
	always_ff @(posedge clk) begin
		if (start) begin
			tagReg <= req.tag;
		end
	end

	assign res = '{prod: prod, tag: tagReg};

endmodule

`default_nettype wire

// File: src/mulControl.sv
`timescale 1ns/1ps
`default_nettype none

module mulControl (
	input  wire               clk,
	input  wire               arstN,
	input  wire               start,
	input  wire               bLsb,
	input  wire               bZero,
	input  wire               grant,
	output mulPkg::mulCtrl_t  ctrl,
	output logic              idle,
	output logic              done
);

	mulPkg::ctrlState_t state;
	mulPkg::ctrlState_t stateNext;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= mulPkg::Idle;
		end else begin
			state <= stateNext;
		end
	end

	// Next state and control word
	always_comb begin
		stateNext = state;
		ctrl = '0;
		case (state)
			mulPkg::Idle: begin
				if (start) begin
					// Load cycle takes the operands and clears the sum
					ctrl.load = 1'b1;
					ctrl.clearProd = 1'b1;
					ctrl.enable = 1'b1;
					stateNext = mulPkg::Run;
				end
			end
			mulPkg::Run: begin
				// One multiplier bit per cycle
				ctrl.enable = 1'b1;
				ctrl.addSel = bLsb;
				if (bZero) begin
					stateNext = mulPkg::Done;
				end
			end
			mulPkg::Done: begin
				// Hold the product until the result bus is ours
				if (grant) begin
					stateNext = mulPkg::Idle;
				end
			end
			default: begin
				stateNext = mulPkg::Idle;
			end
		endcase
	end

	assign idle = (state == mulPkg::Idle);
	assign done = (state == mulPkg::Done);

endmodule

`default_nettype wire

// File: src/mulDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module mulDatapath (
	input  wire                                   clk,
	input  wire                                   arstN,
	input  wire  mulPkg::mulCtrl_t                ctrl,
	input  wire  [mulPkg::DATA_WIDTH-1:0]         opA,
	input  wire  [mulPkg::DATA_WIDTH-1:0]         opB,
	output logic                                  bZero,
	output logic                                  bLsb,
	output logic [mulPkg::PROD_WIDTH-1:0]         prod
);

	// Multiplicand is double width so it can shift left the whole way
	logic [mulPkg::PROD_WIDTH-1:0] aReg;
	logic [mulPkg::PROD_WIDTH-1:0] aNext;
	logic [mulPkg::DATA_WIDTH-1:0] bReg;
	logic [mulPkg::DATA_WIDTH-1:0] bNext;
	logic [mulPkg::PROD_WIDTH-1:0] prodReg;
	logic [mulPkg::PROD_WIDTH-1:0] prodNext;
	logic [mulPkg::PROD_WIDTH-1:0] addResult;

	// Partial sum for the current multiplier bit
	assign addResult = prodReg + aReg;

	// Operand select, load or shift
	always_comb begin
		if (ctrl.load) begin
			aNext = {{mulPkg::DATA_WIDTH{1'b0}}, opA};
			bNext = opB;
		end else begin
			aNext = aReg << 1;
			bNext = bReg >> 1;
		end
	end

	// Accumulator select
	always_comb begin
		if (ctrl.clearProd) begin
			prodNext = '0;
		end else if (ctrl.addSel) begin
			prodNext = addResult;
		end else begin
			prodNext = prodReg;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			aReg <= '0;
			bReg <= '0;
			prodReg <= '0;
		end else if (ctrl.enable) begin
			aReg <= aNext;
			bReg <= bNext;
			prodReg <= prodNext;
		end
	end

	// Bit being consumed this cycle
	assign bLsb = bReg[0];

	// Early stop: nothing left in the multiplier once this bit is shifted out
	assign bZero = (bReg[mulPkg::DATA_WIDTH-1:1] == '0);

	assign prod = prodReg;

endmodule

`default_nettype wire

// File: src/mulPkg.sv
`default_nettype none

package mulPkg;

	// Operand and tag widths, fixed so the structs below have a known size
	localparam int DATA_WIDTH = 32;
	localparam int TAG_WIDTH = 4;
	localparam int PROD_WIDTH = 2 * DATA_WIDTH;

	// One multiply request as it arrives at the cluster
	typedef struct packed {
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic [TAG_WIDTH-1:0]  tag;
	} mulReq_t;

	// Finished product, tagged with the request it answers
	typedef struct packed {
		logic [PROD_WIDTH-1:0] prod;
		logic [TAG_WIDTH-1:0]  tag;
	} mulRes_t;

	// Control word from the engine controller to its datapath
	typedef struct packed {
		// Take new operands into the multiplicand and multiplier registers
		logic load;
		// Zero the product accumulator
		logic clearProd;
		// Add the multiplicand into the accumulator
		logic addSel;
		// Registers update this cycle
		logic enable;
	} mulCtrl_t;

	// Engine controller states
	typedef enum logic [1:0] {
		Idle,
		Run,
		Done
	} ctrlState_t;

endpackage

`default_nettype wire
